//--- Makefile
# Verilator build and run for the gated pulse counter

VERILATOR ?= verilator
TOP       ?= pulse_counter_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/bcd_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_counter #(
    parameter int DIGITS = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  gate_ctrl_pkg::count_ctrl_t ctrl,
    input  logic                       count_strobe,
    output bcd_pkg::bcd_vector_t       count_digits,
    output logic                       count_overflow
);

    // carry[i] is the increment request into digit i
    logic [DIGITS:0] carry;

    // Either control strobe zeroes the whole count
    logic zero_all;

    logic overflow_q;

    assign zero_all = ctrl.clear | ctrl.close;
    assign carry[0] = count_strobe;

    ////////////////////////////////////////
    // Digit chain
    ////////////////////////////////////////

    for (genvar i = 0; i < DIGITS; i++) begin : g_digit
        bcd_pkg::bcd_digit_t digit_q;

        // All lower digits at 9 and a strobe present
        assign carry[i+1] = carry[i] & (digit_q == bcd_pkg::BCD_MAX);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                digit_q <= '0;
            end else if (zero_all) begin
                digit_q <= '0;
            end else if (carry[i]) begin
                if (digit_q == bcd_pkg::BCD_MAX) begin
                    digit_q <= '0;
                end else begin
                    digit_q <= digit_q + 4'd1;
                end
            end
        end

        assign count_digits[i] = digit_q;

        a_digit_legal: assert property (
            @(posedge clk) disable iff (!rst_n)
            digit_q <= bcd_pkg::BCD_MAX
        );
    end

    // Unused upper digits read as zero
    for (genvar j = DIGITS; j < bcd_pkg::MAX_DIGITS; j++) begin : g_unused
        assign count_digits[j] = '0;
    end

    ////////////////////////////////////////
    // Sticky overflow
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow_q <= 1'b0;
        end else if (zero_all) begin
            overflow_q <= 1'b0;
        end else if (carry[DIGITS]) begin
            // Top digit wrapped, stays set until the window closes
            overflow_q <= 1'b1;
        end
    end

    assign count_overflow = overflow_q;

endmodule

`default_nettype wire

//--- design/bcd_pkg.sv
`default_nettype none

// Types for the decimal counting datapath and the published window result
package bcd_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Upper bound on the digit count, fixes the result width
    localparam int MAX_DIGITS = 8;

    // Window sequence number width
    localparam int SEQ_W = 8;

    ////////////////////////////////////////
    // Digit types
    ////////////////////////////////////////

    // One decimal digit, legal values 0 to 9
    typedef logic [3:0] bcd_digit_t;

    // Last legal digit value before the wrap
    localparam bcd_digit_t BCD_MAX = 4'd9;

    // Least significant digit at index 0
    typedef bcd_digit_t [MAX_DIGITS-1:0] bcd_vector_t;

    // Published at the end of every gate window
    typedef struct packed {
        bcd_vector_t      digits;
        logic             overflow;
        logic [SEQ_W-1:0] seq;
    } window_result_t;

endpackage

`default_nettype wire

//--- design/gate_controller.sv
`timescale 1ns/1ps
`default_nettype none

module gate_controller #(
    parameter int DIGITS = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          gate_last,
    input  bcd_pkg::bcd_vector_t          count_digits,
    input  logic                          count_overflow,
    output logic                          timer_run,
    output gate_ctrl_pkg::count_ctrl_t    ctrl,
    output bcd_pkg::window_result_t       result,
    output logic                          result_valid
);

    gate_ctrl_pkg::gate_state_t state_q;

    logic [bcd_pkg::SEQ_W-1:0] seq_q;

    // Count with unused digits forced to zero
    bcd_pkg::bcd_vector_t masked_digits;

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= gate_ctrl_pkg::IDLE;
        end else begin
            case (state_q)
                gate_ctrl_pkg::IDLE: begin
                    if (en) begin
                        state_q <= gate_ctrl_pkg::COUNT;
                    end
                end
                gate_ctrl_pkg::COUNT: begin
                    if (!en) begin
                        state_q <= gate_ctrl_pkg::IDLE;
                    end
                end
                default: state_q <= gate_ctrl_pkg::IDLE;
            endcase
        end
    end

    assign timer_run = (state_q == gate_ctrl_pkg::COUNT);

    // Close on the last window cycle, drops a strobe in that cycle
    always_comb begin
        ctrl.clear = (state_q == gate_ctrl_pkg::IDLE);
        ctrl.close = (state_q == gate_ctrl_pkg::COUNT) && gate_last;
    end

    ////////////////////////////////////////
    // Result capture
    ////////////////////////////////////////

    always_comb begin
        masked_digits = '0;
        for (int i = 0; i < DIGITS && i < bcd_pkg::MAX_DIGITS; i++) begin
            masked_digits[i] = count_digits[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
            seq_q        <= '0;
        end else begin
            result_valid <= ctrl.close;
            if (ctrl.close) begin
                result.digits   <= masked_digits;
                result.overflow <= count_overflow;
                result.seq      <= seq_q;
            end
            // Numbering restarts with every enable
            if (state_q == gate_ctrl_pkg::IDLE) begin
                seq_q <= '0;
            end else if (ctrl.close) begin
                seq_q <= seq_q + 1'b1;
            end
        end
    end

    a_valid_after_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(state_q == gate_ctrl_pkg::COUNT)
    );

endmodule

`default_nettype wire

//--- design/gate_ctrl_pkg.sv
`default_nettype none

// Gate controller state and the strobes it hands to the counter
package gate_ctrl_pkg;

    ////////////////////////////////////////
    // Controller state
    ////////////////////////////////////////

    // IDLE holds everything cleared, COUNT runs back-to-back windows
    typedef enum logic {
        IDLE  = 1'b0,
        COUNT = 1'b1
    } gate_state_t;

    ////////////////////////////////////////
    // Counter control
    ////////////////////////////////////////

    typedef struct packed {
        logic clear;   // hold counter at zero
        logic close;   // last window cycle, restart from zero
    } count_ctrl_t;

endpackage

`default_nettype wire

//--- design/gate_timer.sv
`timescale 1ns/1ps
`default_nettype none

module gate_timer #(
    parameter int GATE_CYCLES = 80000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_run,
    output logic gate_last
);

    localparam int CNT_W = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(GATE_CYCLES - 1);

    // Index of the current cycle within the window
    logic [CNT_W-1:0] cnt_q;

    ////////////////////////////////////////
    // Window counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (!timer_run) begin
            cnt_q <= '0;
        end else if (cnt_q == LAST_CNT) begin
            // Next window starts immediately
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Counter may still hold a stale value in the cycle run drops
    assign gate_last = timer_run && (cnt_q == LAST_CNT);

    // Window index never runs past the last cycle
    a_cnt_in_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt_q <= LAST_CNT
    );

endmodule

`default_nettype wire

//--- design/pulse_counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_counter_top #(
    parameter int GATE_CYCLES = 80000,
    parameter int DIGITS      = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    en,
    input  logic                    pulse,
    output bcd_pkg::window_result_t result,
    output logic                    result_valid
);

    logic                       count_strobe;
    logic                       timer_run;
    logic                       gate_last;
    gate_ctrl_pkg::count_ctrl_t ctrl;
    bcd_pkg::bcd_vector_t       count_digits;
    logic                       count_overflow;

    ////////////////////////////////////////
    // Input conditioning
    ////////////////////////////////////////

    pulse_edge_detect edge_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pulse        (pulse),
        .count_strobe (count_strobe)
    );

    ////////////////////////////////////////
    // Window timing and control
    ////////////////////////////////////////

    gate_timer #(
        .GATE_CYCLES (GATE_CYCLES)
    ) timer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .timer_run (timer_run),
        .gate_last (gate_last)
    );

    gate_controller #(
        .DIGITS (DIGITS)
    ) ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .gate_last      (gate_last),
        .count_digits   (count_digits),
        .count_overflow (count_overflow),
        .timer_run      (timer_run),
        .ctrl           (ctrl),
        .result         (result),
        .result_valid   (result_valid)
    );

    // Decimal count of strobes in the open window
    bcd_counter #(
        .DIGITS (DIGITS)
    ) counter_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .count_strobe   (count_strobe),
        .count_digits   (count_digits),
        .count_overflow (count_overflow)
    );

endmodule

`default_nettype wire

//--- design/pulse_edge_detect.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_edge_detect (
    input  logic clk,
    input  logic rst_n,
    input  logic pulse,
    output logic count_strobe
);

    // Synchronizer stages
    logic sync1_q;
    logic sync2_q;

    // Previous synchronized level
    logic level_q;

    logic strobe_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q  <= 1'b0;
            sync2_q  <= 1'b0;
            level_q  <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            sync1_q  <= pulse;
            sync2_q  <= sync1_q;
            level_q  <= sync2_q;
            // Rising edge of the synchronized level
            strobe_q <= sync2_q & ~level_q;
        end
    end

    assign count_strobe = strobe_q;

    // One strobe per edge, never back to back
    a_strobe_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        count_strobe |=> !count_strobe
    );

endmodule

`default_nettype wire

//--- sim/pulse_counter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_counter_tb;

    localparam int GATE_CYCLES = 2500;
    localparam int DIGITS      = 3;
    localparam int COUNT_MOD   = 10 ** DIGITS;
    localparam int WAIT_LIMIT  = 3 * GATE_CYCLES;
    localparam int SEED        = 32'h3285_93e7;

    localparam int MODE_QUIET  = 0;
    localparam int MODE_SPARSE = 1;
    localparam int MODE_DENSE  = 2;
    localparam int MODE_HIGH   = 3;

    logic                    clk;
    logic                    rst_n;
    logic                    en;
    logic                    pulse;
    bcd_pkg::window_result_t result;
    logic                    result_valid;

    int pulse_mode;
    int err_cnt;
    int tests_run;
    int tests_failed;
    int cycle_cnt;
    int dropped;
    int last_cycle;

    bcd_pkg::window_result_t exp_q[$];
    bcd_pkg::window_result_t last_res;

    // Reference model state
    logic                      m_sync1;
    logic                      m_sync2;
    logic                      m_level;
    logic                      m_strobe;
    logic                      m_run;
    logic                      m_close;
    logic                      m_ovf;
    logic [bcd_pkg::SEQ_W-1:0] m_seq;
    int                        m_tcnt;
    int                        m_count;

    pulse_counter_top #(
        .GATE_CYCLES (GATE_CYCLES),
        .DIGITS      (DIGITS)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .pulse        (pulse),
        .result       (result),
        .result_valid (result_valid)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Pulse stimulus
    ////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        pulse = 1'b0;
        forever begin
            @(posedge clk);
            case (pulse_mode)
                MODE_SPARSE: if ($urandom_range(3, 0) == 0) pulse <= ~pulse;
                // Toggle every cycle for one edge per two clocks
                MODE_DENSE:  pulse <= ~pulse;
                MODE_HIGH:   pulse <= 1'b1;
                default:     pulse <= 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic bcd_pkg::bcd_vector_t to_bcd(input int value);
        bcd_pkg::bcd_vector_t v;
        int rest;
        v = '0;
        rest = value;
        for (int i = 0; i < DIGITS; i++) begin
            v[i] = 4'(rest % 10);
            rest = rest / 10;
        end
        return v;
    endfunction

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (!rst_n) begin
            {m_sync1, m_sync2, m_level, m_strobe, m_run, m_ovf} = '0;
            m_seq   = '0;
            m_tcnt  = 0;
            m_count = 0;
        end else begin
            // Last window cycle closes and loses its strobe
            m_close = m_run && (m_tcnt == GATE_CYCLES - 1);
            if (m_close) begin
                exp_q.push_back({to_bcd(m_count), m_ovf, m_seq});
                m_seq = m_seq + 1'b1;
                if (m_strobe) dropped++;
            end
            if (!m_run || m_close) begin
                m_count = 0;
                m_ovf   = 1'b0;
            end else if (m_strobe) begin
                m_ovf   = m_ovf | (m_count == COUNT_MOD - 1);
                m_count = (m_count + 1) % COUNT_MOD;
            end
            if (!m_run) m_seq = '0;
            m_tcnt   = (!m_run || m_close) ? 0 : m_tcnt + 1;
            m_run    = en;
            // Two sync stages then edge against the previous level
            m_strobe = m_sync2 & ~m_level;
            m_level  = m_sync2;
            m_sync2  = m_sync1;
            m_sync1  = pulse;
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_digits(input bcd_pkg::bcd_vector_t got, input bcd_pkg::bcd_vector_t exp,
                                input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s digits %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s overflow %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_seq(input logic [bcd_pkg::SEQ_W-1:0] got,
                             input logic [bcd_pkg::SEQ_W-1:0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s seq %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_spacing(input int got, input int exp, input string what);
        if (got != exp) begin
            err_cnt++;
            $display("ERR %0t: %s spacing %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    // Next result_valid checked against the model's prediction
    task automatic wait_result(input string what);
        int waited;
        bit seen;
        bcd_pkg::window_result_t exp;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            seen = (result_valid === 1'b1);
        end
        if (!seen) begin
            $display("Timeout in %s: no result_valid within %0d cycles", what, WAIT_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            last_res = result;
            last_cycle = cycle_cnt;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Result at %0t in %s was not predicted by the model", $time, what);
            end else begin
                exp = exp_q.pop_front();
                check_digits(result.digits, exp.digits, what);
                check_overflow(result.overflow, exp.overflow, what);
                check_seq(result.seq, exp.seq, what);
            end
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (result_valid !== 1'b0) begin
                err_cnt++;
                $display("ERR %0t: %s result_valid %b while en was low, expected 0",
                         $time, what, result_valid);
            end
        end
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests_run++;
        if (err_cnt == start_err) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_cnt - start_err);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int start_err;
        int prev_cycle;
        clk = 1'b0;
        rst_n = 1'b0;
        en = 1'b0;
        pulse_mode = MODE_QUIET;
        {err_cnt, tests_run, tests_failed, cycle_cnt, dropped} = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        en <= 1'b1;

        start_err = err_cnt;
        for (int i = 0; i < 3; i++) begin
            wait_result("idle");
            check_digits(last_res.digits, '0, "idle");
            check_overflow(last_res.overflow, 1'b0, "idle");
            check_seq(last_res.seq, 8'(i), "idle");
        end
        finish_test("1 idle", start_err);

        start_err = err_cnt;
        pulse_mode = MODE_SPARSE;
        for (int i = 0; i < 8; i++) wait_result("sparse");
        // Lone edge whose strobe lands on the last window cycle
        pulse_mode = MODE_QUIET;
        wait_result("sparse");
        repeat (GATE_CYCLES - 5) @(negedge clk);
        pulse_mode = MODE_HIGH;
        wait_result("boundary");
        check_digits(last_res.digits, '0, "boundary");
        wait_result("after boundary");
        check_digits(last_res.digits, '0, "after boundary");
        $display("Strobes dropped on the last window cycle: %0d", dropped);
        finish_test("2 sparse pulses", start_err);

        start_err = err_cnt;
        pulse_mode = MODE_DENSE;
        wait_result("dense");
        check_overflow(last_res.overflow, 1'b1, "dense window");
        pulse_mode = MODE_QUIET;
        wait_result("quiet after dense");
        check_overflow(last_res.overflow, 1'b0, "quiet after dense");
        finish_test("3 carries", start_err);

        // Drop en halfway through a window
        start_err = err_cnt;
        pulse_mode = MODE_SPARSE;
        repeat (GATE_CYCLES / 2) @(posedge clk);
        en <= 1'b0;
        expect_quiet(2 * GATE_CYCLES, "disable");
        @(posedge clk);
        en <= 1'b1;
        wait_result("re-enable");
        check_seq(last_res.seq, '0, "re-enable");
        finish_test("4 disable", start_err);

        start_err = err_cnt;
        for (int i = 0; i < 3; i++) begin
            prev_cycle = last_cycle;
            wait_result("spacing");
            check_spacing(last_cycle - prev_cycle, GATE_CYCLES, "spacing");
        end
        finish_test("5 window spacing", start_err);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/bcd_pkg.sv
design/gate_ctrl_pkg.sv
design/pulse_edge_detect.sv
design/gate_timer.sv
design/bcd_counter.sv
design/gate_controller.sv
design/pulse_counter_top.sv
sim/pulse_counter_tb.sv
